// ==== design/core_pkg.sv ====
// shared types for the pipelined core; every stage names them as core_pkg::<type>
`default_nettype none

package core_pkg;

    // major opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // function field of the special opcode
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI  // b operand moved to the upper half
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_REG,  // value read in decode
        FWD_EX,   // alu out sitting in ex_regs
        FWD_MEM   // writeback data in mem_regs
    } forward_type_t;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] pc4;
        logic        valid;
    } if_regs_t;

    typedef struct packed {
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [31:0] a_data;
        logic [31:0] b_data;
        logic [31:0] imm;       // already extended
        alu_op_t     alu_op;
        logic        b_is_reg;  // alu b from rt, else imm
        logic        write_enable;
        logic [4:0]  w_regnum;
        logic        mem_read;
        logic        mem_write;
        logic        is_branch;
        logic        branch_ne;
        logic [31:0] pc4;
        logic        valid;
    } id_regs_t;

    typedef struct packed {
        logic [31:0] out;
        logic [31:0] b_data;  // store data
        logic [4:0]  w_regnum;
        logic        write_enable;
        logic        mem_read;
        logic        mem_write;
        logic        valid;
    } ex_regs_t;

    typedef struct packed {
        logic [31:0] w_data;
        logic [4:0]  w_regnum;
        logic        write_enable;
    } mem_regs_t;

endpackage

`default_nettype wire

// ==== design/core_fetch.sv ====
// fetch stage: program counter and IF register, instantiated once by core
`default_nettype none
`timescale 1ns/100ps

module core_fetch #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              stall,
    input  logic              flush,
    input  logic [31:0]       next_pc,
    input  logic [31:0]       i_data,
    output logic [31:0]       i_addr,
    output core_pkg::if_regs_t if_regs
);
    logic [31:0] pc;

    assign i_addr = pc;  // instruction memory reads combinationally

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= RESET_PC;
            if_regs <= '0;
        end else if (flush) begin
            // redirect to the branch target, drop what was being fetched
            pc      <= next_pc;
            if_regs <= '0;
        end else if (!stall) begin
            pc            <= pc + 32'd4;
            if_regs.inst  <= i_data;
            if_regs.pc    <= pc;
            if_regs.pc4   <= pc + 32'd4;
            if_regs.valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/core_decode.sv ====
// decode stage: control decode, register file and ID register, instantiated by core
`default_nettype none
`timescale 1ns/100ps

module core_decode (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                stall,    // load-use or bus wait
    input  logic                hold,     // bus wait only
    input  logic                flush,
    input  core_pkg::if_regs_t  if_regs,
    input  core_pkg::mem_regs_t mem_regs,
    output core_pkg::id_regs_t  id_regs,
    output logic                rt_used   // instruction in IF reads rt
);
    logic [31:0] regs [32];
    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm16;
    logic        sign_ext;
    core_pkg::id_regs_t id_next;

    assign opcode = if_regs.inst[31:26];
    assign rs     = if_regs.inst[25:21];
    assign rt     = if_regs.inst[20:16];
    assign rd     = if_regs.inst[15:11];
    assign imm16  = if_regs.inst[15:0];
    assign funct  = if_regs.inst[5:0];

    // read with write-before-read bypass from writeback
    function automatic logic [31:0] read_reg(input logic [4:0] num);
        if (num == 5'd0) begin
            return 32'd0;
        end
        if (mem_regs.write_enable && mem_regs.w_regnum == num) begin
            return mem_regs.w_data;
        end
        return regs[num];
    endfunction

    always_ff @(posedge clock) begin
        if (mem_regs.write_enable && mem_regs.w_regnum != 5'd0) begin
            regs[mem_regs.w_regnum] <= mem_regs.w_data;
        end
    end

    always_comb begin
        id_next        = '0;
        id_next.rs     = rs;
        id_next.rt     = rt;
        id_next.a_data = read_reg(rs);
        id_next.b_data = read_reg(rt);
        id_next.pc4    = if_regs.pc4;
        id_next.valid  = if_regs.valid;
        id_next.alu_op = core_pkg::ALU_ADD;
        sign_ext       = 1'b1;
        rt_used        = 1'b0;
        case (opcode)
            core_pkg::OP_SPECIAL: begin
                id_next.b_is_reg     = 1'b1;
                id_next.w_regnum     = rd;
                id_next.write_enable = 1'b1;
                rt_used              = 1'b1;
                case (funct)
                    core_pkg::FN_ADDU: id_next.alu_op = core_pkg::ALU_ADD;
                    core_pkg::FN_SUBU: id_next.alu_op = core_pkg::ALU_SUB;
                    core_pkg::FN_AND:  id_next.alu_op = core_pkg::ALU_AND;
                    core_pkg::FN_OR:   id_next.alu_op = core_pkg::ALU_OR;
                    core_pkg::FN_SLT:  id_next.alu_op = core_pkg::ALU_SLT;
                    default:           id_next.write_enable = 1'b0;  // treated as nop
                endcase
            end
            core_pkg::OP_ADDIU: begin
                id_next.w_regnum     = rt;
                id_next.write_enable = 1'b1;
            end
            core_pkg::OP_ORI: begin
                id_next.alu_op       = core_pkg::ALU_OR;
                id_next.w_regnum     = rt;
                id_next.write_enable = 1'b1;
                sign_ext             = 1'b0;
            end
            core_pkg::OP_LUI: begin
                id_next.alu_op       = core_pkg::ALU_LUI;
                id_next.w_regnum     = rt;
                id_next.write_enable = 1'b1;
                sign_ext             = 1'b0;
            end
            core_pkg::OP_LW: begin
                id_next.w_regnum     = rt;
                id_next.write_enable = 1'b1;
                id_next.mem_read     = 1'b1;
            end
            core_pkg::OP_SW: begin
                id_next.mem_write = 1'b1;  // address from imm, data from rt
                rt_used           = 1'b1;
            end
            core_pkg::OP_BEQ, core_pkg::OP_BNE: begin
                id_next.is_branch = 1'b1;
                id_next.branch_ne = (opcode == core_pkg::OP_BNE);
                id_next.b_is_reg  = 1'b1;
                rt_used           = 1'b1;
            end
            default: ;  // unknown opcode, nop
        endcase
        id_next.imm = sign_ext ? {{16{imm16[15]}}, imm16} : {16'd0, imm16};
        if (!if_regs.valid) begin
            id_next.write_enable = 1'b0;
            id_next.mem_read     = 1'b0;
            id_next.mem_write    = 1'b0;
            id_next.is_branch    = 1'b0;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            id_regs <= '0;
        end else if (hold) begin
            // held operands would go stale once the older write retires
            if (mem_regs.write_enable && mem_regs.w_regnum != 5'd0) begin
                if (mem_regs.w_regnum == id_regs.rs) begin
                    id_regs.a_data <= mem_regs.w_data;
                end
                if (mem_regs.w_regnum == id_regs.rt) begin
                    id_regs.b_data <= mem_regs.w_data;
                end
            end
        end else if (stall || flush) begin
            id_regs <= '0;  // bubble
        end else begin
            id_regs <= id_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/core_hazard.sv ====
// hazard unit: forward selects, load-use stall and bus-wait hold, instantiated by core
`default_nettype none
`timescale 1ns/100ps

module core_hazard (
    input  logic                     [4:0] if_rs,
    input  logic                     [4:0] if_rt,
    input  logic                           if_b_is_reg,  // rt is a source in IF
    input  core_pkg::id_regs_t             id_regs,
    input  core_pkg::ex_regs_t             ex_regs,
    input  core_pkg::mem_regs_t            mem_regs,
    input  logic                           d_valid,
    input  logic                           d_ready,
    output logic                           stall,
    output logic                           bus_hold,
    output core_pkg::forward_type_t        forward_a,
    output core_pkg::forward_type_t        forward_b
);
    logic load_use;

    // youngest producer wins; a load in ex_regs has no data yet
    function automatic core_pkg::forward_type_t pick_source(input logic [4:0] num);
        if (num == 5'd0) begin
            return core_pkg::FWD_REG;
        end
        if (ex_regs.valid && ex_regs.write_enable && !ex_regs.mem_read &&
            ex_regs.w_regnum == num) begin
            return core_pkg::FWD_EX;
        end
        if (mem_regs.write_enable && mem_regs.w_regnum == num) begin
            return core_pkg::FWD_MEM;
        end
        return core_pkg::FWD_REG;
    endfunction

    always_comb begin
        load_use = id_regs.valid && id_regs.mem_read && id_regs.w_regnum != 5'd0 &&
                   (id_regs.w_regnum == if_rs ||
                    (if_b_is_reg && id_regs.w_regnum == if_rt));
        bus_hold  = d_valid && !d_ready;
        stall     = load_use || bus_hold;
        forward_a = pick_source(id_regs.rs);
        forward_b = pick_source(id_regs.rt);
    end

endmodule

`default_nettype wire

// ==== design/core_execute.sv ====
// execute stage: forwarding muxes, ALU, branch resolve and EX register, instantiated by core
`default_nettype none
`timescale 1ns/100ps

module core_execute (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    hold,
    input  core_pkg::id_regs_t      id_regs,
    input  core_pkg::forward_type_t forward_a,
    input  core_pkg::forward_type_t forward_b,
    input  logic [31:0]             mem_data,
    output core_pkg::ex_regs_t      ex_regs,
    output logic                    flush,
    output logic [31:0]             next_pc
);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] alu_b;
    logic [31:0] alu_out;
    logic        taken;
    core_pkg::ex_regs_t ex_next;

    function automatic logic [31:0] operand(input core_pkg::forward_type_t sel,
                                            input logic [31:0] reg_val);
        case (sel)
            core_pkg::FWD_EX:  return ex_regs.out;
            core_pkg::FWD_MEM: return mem_data;
            default:           return reg_val;
        endcase
    endfunction

    always_comb begin
        a     = operand(forward_a, id_regs.a_data);
        b     = operand(forward_b, id_regs.b_data);
        alu_b = id_regs.b_is_reg ? b : id_regs.imm;

        case (id_regs.alu_op)
            core_pkg::ALU_ADD: alu_out = a + alu_b;
            core_pkg::ALU_SUB: alu_out = a - alu_b;
            core_pkg::ALU_AND: alu_out = a & alu_b;
            core_pkg::ALU_OR:  alu_out = a | alu_b;
            core_pkg::ALU_SLT: alu_out = {31'd0, $signed(a) < $signed(alu_b)};
            core_pkg::ALU_LUI: alu_out = {alu_b[15:0], 16'd0};
            default:           alu_out = a + alu_b;
        endcase

        // beq when equal, bne when not
        taken   = id_regs.valid && id_regs.is_branch && ((a == b) != id_regs.branch_ne);
        flush   = taken && !hold;  // fires once the pipe moves again
        next_pc = id_regs.pc4 + {id_regs.imm[29:0], 2'b00};

        ex_next.out          = alu_out;
        ex_next.b_data       = b;
        ex_next.w_regnum     = id_regs.w_regnum;
        ex_next.write_enable = id_regs.write_enable;
        ex_next.mem_read     = id_regs.mem_read;
        ex_next.mem_write    = id_regs.mem_write;
        ex_next.valid        = id_regs.valid;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ex_regs <= '0;
        end else if (!hold) begin
            ex_regs <= ex_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/core_memory.sv ====
// memory stage: data bus request and MEM/writeback register, instantiated by core
`default_nettype none
`timescale 1ns/100ps

module core_memory (
    input  logic                clock,
    input  logic                arst_n,
    input  core_pkg::ex_regs_t  ex_regs,
    input  logic [31:0]         d_rdata,
    input  logic                d_ready,
    output logic                d_valid,
    output core_pkg::mem_regs_t mem_regs
);
    core_pkg::mem_regs_t mem_next;

    always_comb begin
        d_valid = ex_regs.valid && (ex_regs.mem_read || ex_regs.mem_write);

        mem_next.w_data   = ex_regs.mem_read ? d_rdata : ex_regs.out;
        mem_next.w_regnum = ex_regs.w_regnum;
        // nothing retires while the bus is still busy
        mem_next.write_enable = ex_regs.valid && ex_regs.write_enable &&
                                !(d_valid && !d_ready);
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mem_regs <= '0;
        end else begin
            mem_regs <= mem_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/core.sv ====
// top of the four-stage core; the testbench drives the instruction and data ports
`default_nettype none
`timescale 1ns/100ps

module core #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clock,
    input  logic        arst_n,
    // instruction port
    output logic [31:0] i_addr,
    input  logic [31:0] i_data,   // same-cycle read
    // data port
    output logic [31:0] d_addr,
    output logic [31:0] d_wdata,
    output logic        d_write,  // store when set, else load
    input  logic [31:0] d_rdata,
    output logic        d_valid,
    input  logic        d_ready,
    // register writes as they retire
    output logic        wb_valid,
    output logic [4:0]  wb_regnum,
    output logic [31:0] wb_data
);
    logic stall, bus_hold, flush, rt_used;
    logic [31:0] next_pc;
    core_pkg::if_regs_t  if_regs;
    core_pkg::id_regs_t  id_regs;
    core_pkg::ex_regs_t  ex_regs;
    core_pkg::mem_regs_t mem_regs;
    core_pkg::forward_type_t forward_a, forward_b;

    core_fetch #(
        .RESET_PC(RESET_PC)
    ) fetch_stage (
        .clock(clock),
        .arst_n(arst_n),
        .stall(stall),
        .flush(flush),
        .next_pc(next_pc),
        .i_data(i_data),
        .i_addr(i_addr),
        .if_regs(if_regs)
    );

    core_decode decode_stage (
        .clock(clock),
        .arst_n(arst_n),
        .stall(stall),
        .hold(bus_hold),
        .flush(flush),
        .if_regs(if_regs),
        .mem_regs(mem_regs),
        .id_regs(id_regs),
        .rt_used(rt_used)
    );

    core_hazard hazard_unit (
        .if_rs(if_regs.inst[25:21]),
        .if_rt(if_regs.inst[20:16]),
        .if_b_is_reg(rt_used),
        .id_regs(id_regs),
        .ex_regs(ex_regs),
        .mem_regs(mem_regs),
        .d_valid(d_valid),
        .d_ready(d_ready),
        .stall(stall),
        .bus_hold(bus_hold),
        .forward_a(forward_a),
        .forward_b(forward_b)
    );

    core_execute execute_stage (
        .clock(clock),
        .arst_n(arst_n),
        .hold(bus_hold),
        .id_regs(id_regs),
        .forward_a(forward_a),
        .forward_b(forward_b),
        .mem_data(mem_regs.w_data),
        .ex_regs(ex_regs),
        .flush(flush),
        .next_pc(next_pc)
    );

    core_memory memory_stage (
        .clock(clock),
        .arst_n(arst_n),
        .ex_regs(ex_regs),
        .d_rdata(d_rdata),
        .d_ready(d_ready),
        .d_valid(d_valid),
        .mem_regs(mem_regs)
    );

    // data port straight from the EX register
    always_comb begin
        d_addr    = ex_regs.out;
        d_wdata   = ex_regs.b_data;
        d_write   = ex_regs.mem_write;
        wb_valid  = mem_regs.write_enable;
        wb_regnum = mem_regs.w_regnum;
        wb_data   = mem_regs.w_data;
    end

endmodule

`default_nettype wire

// ==== dv/core_checker.sv ====
// checker for the core testbench; compares reset state, writebacks and bus transfers with expected lists
`default_nettype none
`timescale 1ns/100ps

module core_checker #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic              clock,
    input  logic              arst_n,
    input  logic [31:0]       i_addr,
    input  logic              wb_valid,
    input  logic [4:0]        wb_regnum,
    input  logic [31:0]       wb_data,
    input  logic              d_valid,
    input  logic              d_ready,
    input  logic              d_write,
    input  logic [31:0]       d_addr,
    input  logic [31:0]       d_wdata,
    input  logic [15:0][36:0] exp_wb,   // {regnum, data}
    input  int                wb_count,
    input  logic [7:0][64:0]  exp_bus,  // {write, addr, data}
    input  int                bus_count,
    output int                wb_seen,
    output int                bus_seen,
    output int                errors
);
    initial errors = 0;

    // sampled mid-cycle so the values are settled
    always @(negedge clock) begin
        if (!arst_n) begin
            wb_seen  <= 0;
            bus_seen <= 0;
            // nothing moves and fetch sits at the reset address
            if (d_valid || wb_valid || i_addr != RESET_PC) begin
                $display("CHECK FAILED at %0t: in reset d_valid %b wb_valid %b i_addr %h",
                         $time, d_valid, wb_valid, i_addr);
                errors = errors + 1;
            end
        end else begin
            if (wb_valid) begin
                if (wb_seen >= wb_count) begin
                    $display("unexpected writeback r%0d = %h after the expected list at %0t",
                             wb_regnum, wb_data, $time);
                    errors = errors + 1;
                end else if ({wb_regnum, wb_data} != exp_wb[wb_seen]) begin
                    $display("CHECK FAILED at %0t: writeback %0d got r%0d = %h, expected r%0d = %h",
                             $time, wb_seen, wb_regnum, wb_data,
                             exp_wb[wb_seen][36:32], exp_wb[wb_seen][31:0]);
                    errors = errors + 1;
                end
                wb_seen <= wb_seen + 1;
            end
            if (d_valid && d_ready) begin  // one count per handshake
                if (bus_seen >= bus_count) begin
                    $display("unexpected bus transfer to %h after the expected list at %0t",
                             d_addr, $time);
                    errors = errors + 1;
                end else if (d_write != exp_bus[bus_seen][64] ||
                             d_addr != exp_bus[bus_seen][63:32] ||
                             (d_write && d_wdata != exp_bus[bus_seen][31:0])) begin
                    $display("CHECK FAILED at %0t: bus %0d got w=%b addr %h data %h, expected %h",
                             $time, bus_seen, d_write, d_addr, d_wdata, exp_bus[bus_seen]);
                    errors = errors + 1;
                end
                bus_seen <= bus_seen + 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/core_tb.sv ====
// testbench for the core; runs each program of the table against instruction and data memory models
`default_nettype none
`timescale 1ns/100ps

module core_tb;
    localparam logic [31:0] RESET_PC = 32'h0000_0100;
    localparam logic [5:0] ADDU = 6'h21, SUBU = 6'h23, AND = 6'h24, OR = 6'h25, SLT = 6'h2a;
    localparam logic [5:0] ADDIU = 6'h09, ORI = 6'h0d, LUI = 6'h0f, LW = 6'h23, SW = 6'h2b;
    localparam logic [5:0] BEQ = 6'h04, BNE = 6'h05;

    logic clock, arst_n;
    logic [31:0] i_addr, i_data, d_addr, d_wdata, d_rdata, cap_addr, cap_data, offset;
    logic d_write, d_valid, d_ready, wb_valid, cap_write, pending;
    logic [4:0] wb_regnum;
    logic [31:0] wb_data;
    logic [31:0] imem [16];
    logic [31:0] dmem [16];
    logic [15:0][36:0] exp_wb;
    logic [7:0][64:0] exp_bus;
    int wb_count, bus_count, wb_seen, bus_seen, check_errors;
    int timeouts, seed, wait_left;

    // program table: instructions and expected events per row
    logic [31:0] prog_table [3][16];
    logic [36:0] wb_table [3][16];
    logic [64:0] bus_table [3][8];
    int prog_n [3];
    int wb_n [3];
    int bus_n [3];

    core #(.RESET_PC(RESET_PC)) core_inst (
        .clock(clock), .arst_n(arst_n), .i_addr(i_addr), .i_data(i_data),
        .d_addr(d_addr), .d_wdata(d_wdata), .d_write(d_write), .d_rdata(d_rdata),
        .d_valid(d_valid), .d_ready(d_ready),
        .wb_valid(wb_valid), .wb_regnum(wb_regnum), .wb_data(wb_data)
    );

    core_checker #(.RESET_PC(RESET_PC)) checker_inst (
        .clock(clock), .arst_n(arst_n), .i_addr(i_addr), .wb_valid(wb_valid),
        .wb_regnum(wb_regnum), .wb_data(wb_data), .d_valid(d_valid), .d_ready(d_ready),
        .d_write(d_write), .d_addr(d_addr), .d_wdata(d_wdata), .exp_wb(exp_wb),
        .wb_count(wb_count), .exp_bus(exp_bus), .bus_count(bus_count), .wb_seen(wb_seen),
        .bus_seen(bus_seen), .errors(check_errors)
    );

    always #10 clock = ~clock;

    always_comb begin
        offset = i_addr - RESET_PC;
        i_data = (offset < 32'd64) ? imem[offset[5:2]] : 32'd0;  // nop past the program
    end

    // data memory with 0 to 3 wait states per request
    always begin
        @(posedge clock);
        #1;
        if (!arst_n) begin
            d_ready = 1'b0;
            pending = 1'b0;
        end else if (d_ready) begin
            if (cap_write) begin
                dmem[cap_addr[5:2]] = cap_data;
            end
            d_ready = 1'b0;
            pending = 1'b0;
        end else if (d_valid) begin
            if (!pending) begin
                pending   = 1'b1;
                wait_left = $random(seed) & 3;
            end
            if (wait_left == 0) begin
                cap_addr  = d_addr;
                cap_data  = d_wdata;
                cap_write = d_write;
                d_rdata   = dmem[d_addr[5:2]];
                d_ready   = 1'b1;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    function automatic logic [31:0] rtype(input logic [5:0] funct, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_inst(input int r, input logic [31:0] word);
        prog_table[r][prog_n[r]] = word;
        prog_n[r] = prog_n[r] + 1;
    endtask

    task automatic add_wb(input int r, input logic [4:0] regnum, input logic [31:0] data);
        wb_table[r][wb_n[r]] = {regnum, data};
        wb_n[r] = wb_n[r] + 1;
    endtask

    task automatic add_bus(input int r, input logic w, input logic [31:0] addr,
                           input logic [31:0] data);
        bus_table[r][bus_n[r]] = {w, addr, data};
        bus_n[r] = bus_n[r] + 1;
    endtask

    // data memory holds A500_0000 plus the byte address before each program
    task automatic build_table();
        for (int r = 0; r < 3; r++) begin
            prog_n[r] = 0;
            wb_n[r]   = 0;
            bus_n[r]  = 0;
            for (int i = 0; i < 16; i++) begin
                prog_table[r][i] = 32'd0;
            end
        end
        // dependent ALU chain
        add_inst(0, itype(ADDIU, 5'd1, 5'd0, 16'd5));
        add_wb(0, 5'd1, 32'd5);
        add_inst(0, itype(ADDIU, 5'd2, 5'd1, 16'd3));
        add_wb(0, 5'd2, 32'd8);
        add_inst(0, rtype(SUBU, 5'd3, 5'd2, 5'd1));
        add_wb(0, 5'd3, 32'd3);
        add_inst(0, itype(LUI, 5'd4, 5'd0, 16'h1234));
        add_wb(0, 5'd4, 32'h1234_0000);
        add_inst(0, itype(ORI, 5'd4, 5'd4, 16'h5678));
        add_wb(0, 5'd4, 32'h1234_5678);
        add_inst(0, rtype(AND, 5'd5, 5'd4, 5'd2));
        add_wb(0, 5'd5, 32'd8);
        add_inst(0, rtype(OR, 5'd6, 5'd5, 5'd3));
        add_wb(0, 5'd6, 32'hb);
        add_inst(0, rtype(SLT, 5'd7, 5'd3, 5'd2));
        add_wb(0, 5'd7, 32'd1);
        add_inst(0, itype(ADDIU, 5'd8, 5'd0, 16'hffff));
        add_wb(0, 5'd8, 32'hffff_ffff);
        add_inst(0, rtype(SLT, 5'd9, 5'd8, 5'd1));
        add_wb(0, 5'd9, 32'd1);
        add_inst(0, rtype(SLT, 5'd10, 5'd1, 5'd8));
        add_wb(0, 5'd10, 32'd0);
        add_inst(0, rtype(ADDU, 5'd11, 5'd6, 5'd4));
        add_wb(0, 5'd11, 32'h1234_5683);
        add_inst(0, itype(SW, 5'd11, 5'd0, 16'd0));
        add_bus(0, 1'b1, 32'd0, 32'h1234_5683);
        // load-use and store then load
        add_inst(1, itype(ADDIU, 5'd1, 5'd0, 16'd8));
        add_wb(1, 5'd1, 32'd8);
        add_inst(1, itype(LW, 5'd2, 5'd1, 16'd4));
        add_wb(1, 5'd2, 32'ha500_000c);
        add_bus(1, 1'b0, 32'd12, 32'd0);
        add_inst(1, rtype(ADDU, 5'd3, 5'd2, 5'd1));
        add_wb(1, 5'd3, 32'ha500_0014);
        add_inst(1, itype(SW, 5'd3, 5'd0, 16'd16));
        add_bus(1, 1'b1, 32'd16, 32'ha500_0014);
        add_inst(1, itype(LW, 5'd4, 5'd0, 16'd16));
        add_wb(1, 5'd4, 32'ha500_0014);
        add_bus(1, 1'b0, 32'd16, 32'd0);
        add_inst(1, rtype(SUBU, 5'd5, 5'd4, 5'd2));
        add_wb(1, 5'd5, 32'd8);
        add_inst(1, itype(LW, 5'd6, 5'd1, 16'd0));
        add_wb(1, 5'd6, 32'ha500_0008);
        add_bus(1, 1'b0, 32'd8, 32'd0);
        add_inst(1, itype(SW, 5'd5, 5'd1, 16'd20));
        add_bus(1, 1'b1, 32'd28, 32'd8);
        // branches, taken ones squash the next slots
        add_inst(2, itype(ADDIU, 5'd1, 5'd0, 16'd1));
        add_wb(2, 5'd1, 32'd1);
        add_inst(2, itype(ADDIU, 5'd2, 5'd0, 16'd1));
        add_wb(2, 5'd2, 32'd1);
        add_inst(2, itype(BEQ, 5'd2, 5'd1, 16'd2));
        add_inst(2, itype(ADDIU, 5'd3, 5'd0, 16'd7));
        add_inst(2, itype(ADDIU, 5'd4, 5'd0, 16'd7));
        add_inst(2, itype(BNE, 5'd2, 5'd1, 16'd1));
        add_inst(2, itype(ADDIU, 5'd5, 5'd0, 16'd9));
        add_wb(2, 5'd5, 32'd9);
        add_inst(2, itype(BNE, 5'd1, 5'd5, 16'd1));
        add_inst(2, itype(ADDIU, 5'd6, 5'd0, 16'd6));
        add_inst(2, itype(LW, 5'd7, 5'd0, 16'd0));
        add_wb(2, 5'd7, 32'ha500_0000);
        add_bus(2, 1'b0, 32'd0, 32'd0);
        add_inst(2, itype(BEQ, 5'd0, 5'd7, 16'd1));
        add_inst(2, itype(ADDIU, 5'd8, 5'd7, 16'd1));
        add_wb(2, 5'd8, 32'ha500_0001);
        add_inst(2, itype(SW, 5'd8, 5'd0, 16'd4));
        add_bus(2, 1'b1, 32'd4, 32'ha500_0001);
    endtask

    task automatic run_program(input int r);
        int cycles;
        @(posedge clock);
        #1;
        arst_n = 1'b0;
        for (int i = 0; i < 16; i++) begin
            imem[i] = prog_table[r][i];
            dmem[i] = 32'ha500_0000 + 32'(i * 4);
            exp_wb[i] = wb_table[r][i];
        end
        for (int i = 0; i < 8; i++) begin
            exp_bus[i] = bus_table[r][i];
        end
        wb_count  = wb_n[r];
        bus_count = bus_n[r];
        repeat (2) @(negedge clock);  // reset state sampled by the checker
        @(posedge clock);
        #1;
        arst_n = 1'b1;
        cycles = 0;
        while (!(wb_seen == wb_count && bus_seen == bus_count) && cycles < 200) begin
            @(posedge clock);
            cycles = cycles + 1;
        end
        if (cycles >= 200) begin
            $display("program %0d timed out with %0d/%0d writebacks and %0d/%0d bus transfers",
                     r, wb_seen, wb_count, bus_seen, bus_count);
            timeouts = timeouts + 1;
        end
        repeat (10) @(posedge clock);  // any stray event shows up here
    endtask

    initial begin
        clock     = 1'b0;
        arst_n    = 1'b0;
        d_ready   = 1'b0;
        d_rdata   = 32'd0;
        pending   = 1'b0;
        wait_left = 0;
        seed      = 89;
        timeouts  = 0;
        build_table();
        for (int r = 0; r < 3; r++) begin
            run_program(r);
        end
        $display("errors: %0d checker, %0d timeouts", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
design/core_pkg.sv
design/core_fetch.sv
design/core_decode.sv
design/core_hazard.sv
design/core_execute.sv
design/core_memory.sv
design/core.sv
dv/core_checker.sv
dv/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
verilator --binary --timing --top-module core_tb -f files.f -o core_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/core_sim > sim.log 2>&1 || { echo "simulation did not finish cleanly"; exit 1; }
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation reported failure"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "no pass message in sim.log"; exit 1; }
echo "simulation passed"
